//--- design/adc_regs_pkg.sv
`default_nettype none

package adc_regs_pkg;

  // gain word field width, fixed by the byte layout
  parameter int vmag_mag_w = 5;

  // adc control byte as written at the adc control address
  typedef struct packed {
    logic adc_reset;  // bit 7
    logic sen;        // bit 6, serial enable, active low at the adc
    logic spare;      // bit 5, ignored
    logic sdata;      // bit 4, serial data to adc
    logic dfs;        // bit 3, data format select
    logic oe_n;       // bit 2, inverted onto the oe pin
    logic shift;      // bit 1, sample sdout on this write
    logic sclk;       // bit 0, serial clock level
  } adc_ctrl_bits_s;

  // gain byte as written at the vmag address
  typedef struct packed {
    logic [7-vmag_mag_w:0] spare;  // upper bits unused
    logic [vmag_mag_w-1:0] mag;    // magnitude code
  } vmag_word_s;

  // one write byte, two decodes depending on target address
  typedef union packed {
    adc_ctrl_bits_s ctrl;
    vmag_word_s     vmag;
  } reg_wdata_u;

  // levels actually driven onto the adc config pins
  typedef struct packed {
    logic adc_reset;
    logic sen;
    logic sdata;
    logic dfs;
    logic oe;
    logic sclk;
  } adc_pins_s;

  // serial port idle, outputs enabled, adc out of reset
  parameter adc_pins_s adc_pins_reset = '{
    adc_reset: 1'b0,
    sen:       1'b1,
    sdata:     1'b0,
    dfs:       1'b0,
    oe:        1'b1,
    sclk:      1'b1
  };

endpackage : adc_regs_pkg

`default_nettype wire

//--- design/husky_adc_top.sv
`timescale 1ns/1ps
`default_nettype none

module husky_adc_top #(
  parameter int vmag_width = 5  // amp gain bits actually wired out
) (
  input  logic                               clk_usb,
  input  logic                               reset_i,
  // host byte bus
  input  logic [usb_bus_pkg::usb_addr_w-1:0] usb_addr,
  input  logic [usb_bus_pkg::reg_data_w-1:0] usb_din,
  output logic [usb_bus_pkg::reg_data_w-1:0] usb_dout,
  output logic                               usb_isout,
  input  logic                               usb_cen_n,
  input  logic                               usb_alen_n,
  input  logic                               usb_rdn,
  input  logic                               usb_wrn,
  // adc config port
  output logic                               adc_reset,
  output logic                               adc_sen,
  output logic                               adc_sdata,
  output logic                               adc_dfs,
  output logic                               adc_oe,
  output logic                               adc_sclk,
  input  logic                               adc_ovr_sdout,
  // amplifier gain
  output logic [vmag_width-1:0]              vmag_d
);

  reg_bus_if i_reg_bus ();  // front end to register block

  // host strobes in, level register bus out
  usb_reg_fe i_usb_reg_fe (
    .clk_usb    (clk_usb),
    .reset_i    (reset_i),
    .usb_addr   (usb_addr),
    .usb_din    (usb_din),
    .usb_dout   (usb_dout),
    .usb_isout  (usb_isout),
    .usb_cen_n  (usb_cen_n),
    .usb_alen_n (usb_alen_n),
    .usb_rdn    (usb_rdn),
    .usb_wrn    (usb_wrn),
    .bus        (i_reg_bus.host)
  );

  // adc bit-bang and gain registers
  reg_husky_adc #(
    .vmag_width (vmag_width)
  ) i_reg_husky_adc (
    .clk_usb       (clk_usb),
    .reset_i       (reset_i),
    .bus           (i_reg_bus.target),
    .adc_reset     (adc_reset),
    .adc_sen       (adc_sen),
    .adc_sdata     (adc_sdata),
    .adc_dfs       (adc_dfs),
    .adc_oe        (adc_oe),
    .adc_sclk      (adc_sclk),
    .adc_ovr_sdout (adc_ovr_sdout),
    .vmag_d        (vmag_d)
  );

endmodule : husky_adc_top

`default_nettype wire

//--- design/reg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
  import usb_bus_pkg::*;

  logic [reg_addr_w-1:0] reg_address;   // latched low address bits
  logic [reg_data_w-1:0] reg_datai;     // write data from host
  logic [reg_data_w-1:0] reg_datao;     // read data back to host
  logic                  reg_read;      // level, whole host read strobe
  logic                  reg_write;     // level, whole host write strobe
  logic                  reg_addrvalid; // cen active and address latched

  // front end side
  modport host (
    output reg_address, reg_datai, reg_read, reg_write, reg_addrvalid,
    input  reg_datao
  );

  // register block side
  modport target (
    input  reg_address, reg_datai, reg_read, reg_write, reg_addrvalid,
    output reg_datao
  );

endinterface : reg_bus_if

`default_nettype wire

//--- design/reg_husky_adc.sv
`timescale 1ns/1ps
`default_nettype none

// bit-bang port for an ADS4128 style adc config interface plus amp gain
//
// every fresh write at the adc control address copies the byte onto the pins
// with the shift bit set, that same write also samples sdout into a byte
// that reads back at the same address. a serial read of the adc is then
// a run of writes 01,02,01,02... with sclk toggling, then one host read
module reg_husky_adc #(
  parameter int vmag_width = 5  // 1..5, gain byte only has 5 magnitude bits
) (
  input  logic                  clk_usb,
  input  logic                  reset_i,
  reg_bus_if.target             bus,
  output logic                  adc_reset,
  output logic                  adc_sen,
  output logic                  adc_sdata,
  output logic                  adc_dfs,
  output logic                  adc_oe,
  output logic                  adc_sclk,
  input  logic                  adc_ovr_sdout,
  output logic [vmag_width-1:0] vmag_d
);
  import usb_bus_pkg::*;
  import adc_regs_pkg::*;

  reg_wdata_u            wdata;         // write byte, decoded per address
  adc_pins_s             pins;          // pin levels
  logic [reg_data_w-1:0] shift_byte;    // sdout samples, newest in bit 0
  logic [reg_data_w-1:0] vmag_ext;      // gain word zero extended for reads
  logic [reg_data_w-1:0] datao_reg;     // read mux output, registered
  logic                  datao_valid;   // last cycle hit a mapped address
  logic                  reg_write_r;   // for the write edge
  logic                  write_rise;
  logic                  hit_adc;
  logic                  hit_vmag;

  assign wdata      = bus.reg_datai;
  assign write_rise = bus.reg_write & ~reg_write_r;  // one action per host strobe
  assign hit_adc    = (bus.reg_address == adc_ctrl_addr);
  assign hit_vmag   = (bus.reg_address == vmag_ctrl_addr);

  // pins straight out of the struct
  assign adc_reset = pins.adc_reset;
  assign adc_sen   = pins.sen;
  assign adc_sdata = pins.sdata;
  assign adc_dfs   = pins.dfs;
  assign adc_oe    = pins.oe;
  assign adc_sclk  = pins.sclk;

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      reg_write_r <= 1'b0;
    end else begin
      reg_write_r <= bus.reg_write;
    end
  end

  // adc bit-bang, pins and readback shifter
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      pins       <= adc_pins_reset;
      shift_byte <= '0;
    end else if (write_rise && hit_adc) begin
      pins.adc_reset <= wdata.ctrl.adc_reset;
      pins.sen       <= wdata.ctrl.sen;
      pins.sdata     <= wdata.ctrl.sdata;
      pins.dfs       <= wdata.ctrl.dfs;
      pins.oe        <= ~wdata.ctrl.oe_n;  // byte carries it inverted
      pins.sclk      <= wdata.ctrl.sclk;
      if (wdata.ctrl.shift) begin
        shift_byte <= {shift_byte[reg_data_w-2:0], adc_ovr_sdout};  // msb first
      end
    end
  end

  // gain word, loads for the whole strobe
  // reloading the same byte each cycle is harmless
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      vmag_d <= '0;
    end else if (bus.reg_write && hit_vmag) begin
      vmag_d <= wdata.vmag.mag[vmag_width-1:0];
    end
  end

  assign vmag_ext = {{(reg_data_w - vmag_width){1'b0}}, vmag_d};

  // read side, data is zero unless the address was mapped last cycle
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      datao_valid <= 1'b0;
    end else begin
      datao_valid <= bus.reg_addrvalid & (hit_adc | hit_vmag);
    end
  end

  always_ff @(posedge clk_usb) begin
    if (bus.reg_read) begin
      if (hit_adc) begin
        datao_reg <= shift_byte;
      end else if (hit_vmag) begin
        datao_reg <= vmag_ext;
      end else begin
        datao_reg <= '0;  // unmapped
      end
    end
  end

  assign bus.reg_datao = datao_valid ? datao_reg : '0;

endmodule : reg_husky_adc

`default_nettype wire

//--- design/usb_bus_pkg.sv
`default_nettype none

package usb_bus_pkg;

  // host side byte bus
  parameter int usb_addr_w = 8;   // full host address
  parameter int reg_addr_w = 6;   // register bus only sees low bits
  parameter int reg_data_w = 8;   // byte wide both ways

  // register address map
  parameter logic [reg_addr_w-1:0] adc_ctrl_addr  = 6'd60;  // adc bit-bang + readback
  parameter logic [reg_addr_w-1:0] vmag_ctrl_addr = 6'd61;  // amplifier gain word

endpackage : usb_bus_pkg

`default_nettype wire

//--- design/usb_reg_fe.sv
`timescale 1ns/1ps
`default_nettype none

module usb_reg_fe (
  input  logic                              clk_usb,
  input  logic                              reset_i,
  input  logic [usb_bus_pkg::usb_addr_w-1:0] usb_addr,
  input  logic [usb_bus_pkg::reg_data_w-1:0] usb_din,
  output logic [usb_bus_pkg::reg_data_w-1:0] usb_dout,
  output logic                              usb_isout,
  input  logic                              usb_cen_n,
  input  logic                              usb_alen_n,
  input  logic                              usb_rdn,
  input  logic                              usb_wrn,
  reg_bus_if.host                           bus
);
  import usb_bus_pkg::*;

  logic                  cen_r;      // registered host strobes, active low
  logic                  wrn_r;
  logic                  rdn_r;
  logic [reg_data_w-1:0] din_r;      // write byte, aligned with wrn_r
  logic                  addr_seen;  // address phase done in this cen window
  logic                  rd_d;       // reg_read one cycle late
  logic                  addr_phase;
  logic                  rd_capture;

  // address phase needs both alen and cen low
  assign addr_phase = ~usb_alen_n & ~usb_cen_n;

  // second cycle of reg_read, register block output is valid by now
  assign rd_capture = bus.reg_read & rd_d & ~usb_isout;

  // first stage, host strobes idle high
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      cen_r <= 1'b1;
      wrn_r <= 1'b1;
      rdn_r <= 1'b1;
    end else begin
      cen_r <= usb_cen_n;
      wrn_r <= usb_wrn;
      rdn_r <= usb_rdn;
    end
  end

  always_ff @(posedge clk_usb) begin
    din_r <= usb_din;  // no reset, qualified by wrn_r downstream
  end

  // address latch, only low bits go onto the register bus
  always_ff @(posedge clk_usb) begin
    if (addr_phase) begin
      bus.reg_address <= usb_addr[reg_addr_w-1:0];
    end
  end

  // valid from the address phase until cen goes back high
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      addr_seen         <= 1'b0;
      bus.reg_addrvalid <= 1'b0;
    end else begin
      if (addr_phase) begin
        addr_seen <= 1'b1;
      end else if (cen_r) begin
        addr_seen <= 1'b0;  // chip deselected, forget address
      end
      bus.reg_addrvalid <= addr_seen & ~cen_r;
    end
  end

  // level strobes, one cycle behind the sampled pins
  // no edge detect here, the register block does that
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      bus.reg_write <= 1'b0;
      bus.reg_read  <= 1'b0;
      rd_d          <= 1'b0;
    end else begin
      bus.reg_write <= ~wrn_r & ~cen_r;
      bus.reg_read  <= ~rdn_r & ~cen_r;
      rd_d          <= bus.reg_read;
    end
  end

  // write data follows the strobe
  always_ff @(posedge clk_usb) begin
    if (~wrn_r) begin
      bus.reg_datai <= din_r;
    end
  end

  // read return, capture once then hold until the host lets go of rdn
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      usb_isout <= 1'b0;
    end else if (rdn_r) begin
      usb_isout <= 1'b0;  // strobe gone, release the bus
    end else if (rd_capture) begin
      usb_isout <= 1'b1;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (rd_capture) begin
      usb_dout <= bus.reg_datao;  // held for rest of the strobe
    end
  end

endmodule : usb_reg_fe

`default_nettype wire

//--- project.f
design/usb_bus_pkg.sv
design/adc_regs_pkg.sv
design/reg_bus_if.sv
design/usb_reg_fe.sv
design/reg_husky_adc.sv
design/husky_adc_top.sv
testbench/husky_adc_assert.sv
testbench/husky_adc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the husky adc testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module husky_adc_tb -f project.f \
  --Mdir "$build_dir" -o husky_adc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/husky_adc_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict from the log
if grep -q "TB FAILED" "$log"; then
  exit 1
fi
if ! grep -q "TB PASSED" "$log"; then
  echo "no pass line in $log"
  exit 1
fi
exit 0

//--- testbench/husky_adc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module husky_adc_assert #(
  parameter int vmag_width = 5
) (
  input logic                               clk_usb,
  input logic                               reset_i,
  input logic                               reg_write,
  input logic                               reg_addrvalid,
  input logic [usb_bus_pkg::reg_addr_w-1:0] reg_address,
  input logic [usb_bus_pkg::reg_data_w-1:0] reg_datao,
  input adc_regs_pkg::adc_pins_s            pins,
  input logic [vmag_width-1:0]              vmag_d
);
  import usb_bus_pkg::*;

  // pins move only on the edge after reg_write rises at the adc address
  a_pins_on_write: assert property (@(posedge clk_usb) disable iff (reset_i)
    (pins != $past(pins)) |->
      ($past(reg_write) && !$past(reg_write, 2) && ($past(reg_address) == adc_ctrl_addr)))
    else $error("adc pins changed without a write edge at the adc control address");

  // read data gated by last cycle's addrvalid
  a_datao_gated: assert property (@(posedge clk_usb) disable iff (reset_i)
    !$past(reg_addrvalid) |-> (reg_datao == '0))
    else $error("reg_datao nonzero after a cycle without addrvalid");

  a_vmag_on_write: assert property (@(posedge clk_usb) disable iff (reset_i)
    (vmag_d != $past(vmag_d)) |-> ($past(reg_write) && ($past(reg_address) == vmag_ctrl_addr)))
    else $error("vmag_d changed without a write at the gain address");  // level write

endmodule : husky_adc_assert

bind reg_husky_adc husky_adc_assert #(
  .vmag_width (vmag_width)
) i_husky_adc_assert (
  .clk_usb       (clk_usb),
  .reset_i       (reset_i),
  .reg_write     (bus.reg_write),
  .reg_addrvalid (bus.reg_addrvalid),
  .reg_address   (bus.reg_address),
  .reg_datao     (bus.reg_datao),
  .pins          (pins),
  .vmag_d        (vmag_d)
);

`default_nettype wire

//--- testbench/husky_adc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module husky_adc_tb;
  import usb_bus_pkg::*;
  import adc_regs_pkg::*;

  localparam int vmag_width  = 5;
  localparam int max_records = 64;
  localparam int rec_bytes   = 5;  // op, addr, data, sdout, test

  logic                  clk_usb;
  logic                  reset_i;
  logic [usb_addr_w-1:0] usb_addr;
  logic [reg_data_w-1:0] usb_din;
  logic [reg_data_w-1:0] usb_dout;
  logic                  usb_isout;
  logic                  usb_cen_n;
  logic                  usb_alen_n;
  logic                  usb_rdn;
  logic                  usb_wrn;
  logic                  adc_reset;
  logic                  adc_sen;
  logic                  adc_sdata;
  logic                  adc_dfs;
  logic                  adc_oe;
  logic                  adc_sclk;
  logic                  adc_ovr_sdout;  // adc serial out model, level per record
  logic [vmag_width-1:0] vmag_d;

  logic [7:0]            test_mem [0:max_records*rec_bytes-1];
  adc_pins_s             exp_pins;       // reference model state
  logic [reg_data_w-1:0] exp_shift;
  logic [vmag_width-1:0] exp_vmag;
  logic [7:0]            op;
  logic [7:0]            rec_addr;
  logic [7:0]            rec_data;
  logic                  rec_sdout;
  logic [7:0]            rec_test;
  logic [7:0]            cur_test;
  logic [reg_data_w-1:0] rd_data;
  logic                  rd_isout;
  int                    errors;
  int                    checks;
  int                    test_errors;
  int                    tests_done;
  int                    num_records;
  int                    cycles;
  int                    cycle_limit;

  husky_adc_top #(
    .vmag_width (vmag_width)
  ) i_husky_adc_top (
    .clk_usb       (clk_usb),
    .reset_i       (reset_i),
    .usb_addr      (usb_addr),
    .usb_din       (usb_din),
    .usb_dout      (usb_dout),
    .usb_isout     (usb_isout),
    .usb_cen_n     (usb_cen_n),
    .usb_alen_n    (usb_alen_n),
    .usb_rdn       (usb_rdn),
    .usb_wrn       (usb_wrn),
    .adc_reset     (adc_reset),
    .adc_sen       (adc_sen),
    .adc_sdata     (adc_sdata),
    .adc_dfs       (adc_dfs),
    .adc_oe        (adc_oe),
    .adc_sclk      (adc_sclk),
    .adc_ovr_sdout (adc_ovr_sdout),
    .vmag_d        (vmag_d)
  );

  initial clk_usb = 1'b0;
  always #4 clk_usb = ~clk_usb;  // 8 ns period

  // run limit, whole sequence must finish well inside this
  always @(posedge clk_usb) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, test sequence did not complete", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // control byte to pin levels, oe is the inverse of bit 2
  function automatic adc_pins_s decode_ctrl_byte(input logic [7:0] b);
    adc_pins_s p;
    p.adc_reset = b[7];
    p.sen       = b[6];
    p.sdata     = b[4];
    p.dfs       = b[3];
    p.oe        = ~b[2];
    p.sclk      = b[0];
    return p;
  endfunction

  function automatic adc_pins_s sample_pins();
    return {adc_reset, adc_sen, adc_sdata, adc_dfs, adc_oe, adc_sclk};
  endfunction

  function automatic logic [reg_data_w-1:0] gain_byte(input logic [vmag_width-1:0] v);
    return {{(reg_data_w - vmag_width){1'b0}}, v};
  endfunction

  // read value the model predicts, only low address bits decode
  function automatic logic [reg_data_w-1:0] expected_read(input logic [7:0] addr);
    if (addr[reg_addr_w-1:0] == adc_ctrl_addr) begin
      return exp_shift;
    end else if (addr[reg_addr_w-1:0] == vmag_ctrl_addr) begin
      return gain_byte(exp_vmag);
    end
    return '0;  // unmapped
  endfunction

  // records up to the end marker, 0 if the file is bad
  function automatic int count_records();
    int n;
    n = 0;
    while (n < max_records && test_mem[n*rec_bytes] inside {8'h1, 8'h2, 8'h3, 8'h4}) begin
      n++;
    end
    if (n == max_records || test_mem[n*rec_bytes] !== 8'h00) begin
      return 0;
    end
    return n;
  endfunction

  task automatic update_model(input logic [7:0] addr, input logic [7:0] data, input logic sdout);
    if (addr[reg_addr_w-1:0] == adc_ctrl_addr) begin
      exp_pins = decode_ctrl_byte(data);
      if (data[1]) begin
        exp_shift = {exp_shift[reg_data_w-2:0], sdout};  // newest bit at the bottom
      end
    end else if (addr[reg_addr_w-1:0] == vmag_ctrl_addr) begin
      exp_vmag = data[vmag_width-1:0];
    end
  endtask

  task automatic check_pins(input adc_pins_s got, input adc_pins_s exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s, pins got %b expected %b", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_byte(input logic [reg_data_w-1:0] got, input logic [reg_data_w-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input logic [7:0] num);
    if (test_errors == 0) begin
      $display("test %0d: ok", num);
    end else begin
      $display("test %0d: %0d errors", num, test_errors);
    end
    tests_done++;
    test_errors = 0;
  endtask

  task automatic step_cycle();
    @(posedge clk_usb);
    #1;  // inputs move just after the edge
  endtask

  task automatic addr_phase(input logic [7:0] addr);
    usb_addr   = addr;
    usb_cen_n  = 1'b0;
    usb_alen_n = 1'b0;
    step_cycle();
    usb_alen_n = 1'b1;
  endtask

  // strobe held for hold cycles, then 2 idle cycles and deselect
  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data, input int hold);
    addr_phase(addr);
    usb_din = data;
    usb_wrn = 1'b0;
    repeat (hold) step_cycle();
    usb_wrn = 1'b1;
    repeat (2) step_cycle();
    usb_cen_n = 1'b1;
    step_cycle();
  endtask

  // usb_dout is valid in the 4th strobe cycle
  task automatic read_reg(input logic [7:0] addr, output logic [7:0] data, output logic isout);
    addr_phase(addr);
    usb_rdn = 1'b0;
    repeat (4) step_cycle();
    data    = usb_dout;
    isout   = usb_isout;
    usb_rdn = 1'b1;
    repeat (2) step_cycle();
    usb_cen_n = 1'b1;
    step_cycle();
  endtask

  initial begin
    usb_addr      = '0;
    usb_din       = '0;
    usb_cen_n     = 1'b1;
    usb_alen_n    = 1'b1;
    usb_rdn       = 1'b1;
    usb_wrn       = 1'b1;
    adc_ovr_sdout = 1'b0;
    reset_i       = 1'b1;
    errors        = 0;
    checks        = 0;
    test_errors   = 0;
    tests_done    = 0;
    cycles        = 0;
    cur_test      = 8'h00;
    exp_pins      = adc_pins_reset;
    exp_shift     = '0;
    exp_vmag      = '0;
    $readmemh("testbench/husky_adc_testdata.txt", test_mem);
    num_records = count_records();
    cycle_limit = 12 * num_records + 50;
    repeat (3) @(posedge clk_usb);
    #1 reset_i = 1'b0;

    if (num_records == 0) begin
      $display("data file missing, empty or without an end record");
    end
    for (int r = 0; r < num_records; r++) begin
      op        = test_mem[r*rec_bytes];
      rec_addr  = test_mem[r*rec_bytes+1];
      rec_data  = test_mem[r*rec_bytes+2];
      rec_sdout = test_mem[r*rec_bytes+3][0];
      rec_test  = test_mem[r*rec_bytes+4];
      if (rec_test != cur_test) begin
        if (cur_test != 8'h00) begin
          report_test(cur_test);
        end
        cur_test = rec_test;
      end
      case (op)
        8'h1, 8'h2: begin  // 2 holds the strobe for 6 cycles
          adc_ovr_sdout = rec_sdout;
          write_reg(rec_addr, rec_data, (op == 8'h2) ? 6 : 3);
          update_model(rec_addr, rec_data, rec_sdout);
          check_pins(sample_pins(), exp_pins, "pins after write");
          check_byte(gain_byte(vmag_d), gain_byte(exp_vmag), "gain word after write");
        end
        8'h3: begin
          read_reg(rec_addr, rd_data, rd_isout);
          if (!rd_isout) begin
            $display("read of address %h did not drive usb_isout in its last cycle", rec_addr);
            errors++;
            test_errors++;
          end
          check_byte(rd_data, rec_data, "read data vs file");
          check_byte(rd_data, expected_read(rec_addr), "read data vs model");
        end
        default: begin  // idle state check
          check_pins(sample_pins(), exp_pins, "idle pins");
          check_byte(gain_byte(vmag_d), gain_byte(exp_vmag), "idle gain word");
          if (usb_isout) begin
            $display("usb_isout is high while the bus is idle");
            errors++;
            test_errors++;
          end
        end
      endcase
    end
    if (cur_test != 8'h00) begin
      report_test(cur_test);
    end

    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (num_records > 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : husky_adc_tb

`default_nettype wire

//--- testbench/husky_adc_testdata.txt
// columns: op addr data sdout test, all hex
// op 1 write, 2 held write, 3 read and compare data, 4 idle check, 0 end
4 00 00 0 01
3 3c 00 0 01
1 3c 91 0 02
1 3c 4c 0 02
1 3c d9 0 02
1 3c 40 0 02
3 3c 00 0 02
// serial readback of a5, msb first
1 3c 01 0 03
1 3c 02 1 03
1 3c 01 0 03
1 3c 02 0 03
1 3c 01 0 03
1 3c 02 1 03
1 3c 01 0 03
1 3c 02 0 03
1 3c 01 0 03
1 3c 02 0 03
1 3c 01 0 03
1 3c 02 1 03
1 3c 01 0 03
1 3c 02 0 03
1 3c 01 0 03
1 3c 02 1 03
3 3c a5 0 03
// long strobes, one shift each
2 3c 02 1 04
2 3c 03 0 04
3 3c 96 0 04
1 3c 02 1 04
3 3c 2d 0 04
1 3d 17 0 05
3 3d 17 0 05
1 3d ea 0 05
3 3d 0a 0 05
1 3e ff 0 05
3 3e 00 0 05
3 3c 2d 0 05
0 00 00 0 00
